// File: all.f
+incdir+verilog
verilog/accel_mem_pkg.sv
verilog/accel_ctrl_pkg.sv
verilog/file_table.sv
verilog/scratch_ram.sv
verilog/byte_transfer.sv
verilog/dense_engine.sv
verilog/dense_accel_top.sv
bench/accel_checker.sv
bench/tb_dense_accel.sv

// File: bench/accel_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module accel_checker
    import accel_mem_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire byte_t rx_data,
    input  wire        rx_valid,
    input  wire byte_t tx_data,
    input  wire        tx_valid,
    input  wire        tx_busy
);

    byte_t model_mem [`ACCEL_MEM_DEPTH];
    byte_t expect_q [$];
    int    pending = 0;
    int    phase = 0;   // 0 header, 1 index high, 2 index low, 3 write data
    logic  is_read = 1'b0;
    byte_t idx_hi;
    int    wr_ptr;
    int    wr_last;
    string test_name = "none";
    int    test_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;

    task automatic note_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic expect_byte(input byte_t b);
        expect_q.push_back(b);
        pending = expect_q.size();
    endtask

    // Address ranges of the four files, anything else is empty
    function automatic logic file_range(input file_t f, output int first, output int last);
        first = 0;
        last  = -1;
        case (f)
            16'd0: begin
                first = `ACCEL_IN_BASE;
                last  = `ACCEL_MAT_BASE - 1;
            end
            16'd1: begin
                first = `ACCEL_MAT_BASE;
                last  = `ACCEL_BIAS_BASE - 1;
            end
            16'd2: begin
                first = `ACCEL_BIAS_BASE;
                last  = `ACCEL_ANS_BASE - 1;
            end
            16'd3: begin
                first = `ACCEL_ANS_BASE;
                last  = `ACCEL_MEM_DEPTH - 1;
            end
            default: ;
        endcase
        return last >= first;
    endfunction

    // Bias plus dot product, low byte kept
    task automatic compute_model();
        acc_t acc;
        int   o;
        int   i;
        for (o = 0; o < `ACCEL_N_OUT; o++) begin
            acc = acc_t'(model_mem[`ACCEL_BIAS_BASE + o]);
            for (i = 0; i < `ACCEL_N_IN; i++)
                acc = acc + model_mem[`ACCEL_IN_BASE + i] *
                      model_mem[`ACCEL_MAT_BASE + o * `ACCEL_N_IN + i];
            model_mem[`ACCEL_ANS_BASE + o] = acc[7:0];
        end
    endtask

    task automatic take_rx(input byte_t b);
        int first;
        int last;
        int a;
        if (pending == 0) begin   // Read or compute in flight drops rx
            case (phase)
                0: begin
                    if (b == `ACCEL_HDR_CALC) begin
                        compute_model();
                        expect_byte(`ACCEL_ACK_DONE);
                    end else if (b == `ACCEL_HDR_READ || b == `ACCEL_HDR_WRITE) begin
                        is_read = (b == `ACCEL_HDR_READ);
                        phase   = 1;
                    end
                end
                1: begin
                    idx_hi = b;
                    phase  = 2;
                end
                2: begin
                    phase = 0;
                    if (file_range({idx_hi, b}, first, last)) begin
                        if (is_read) begin
                            for (a = first; a <= last; a++)
                                expect_byte(model_mem[a]);
                        end else begin
                            wr_ptr  = first;
                            wr_last = last;
                            phase   = 3;
                        end
                    end
                end
                default: begin
                    model_mem[wr_ptr] = b;
                    if (wr_ptr == wr_last)
                        phase = 0;
                    else
                        wr_ptr++;
                end
            endcase
        end
    endtask

    task automatic take_tx(input byte_t b);
        byte_t exp;
        if (tx_busy)
            note_error("tx_valid was raised while tx_busy was high");
        if (expect_q.size() == 0) begin
            note_error($sformatf("tx byte 0x%02h arrived with no reply pending", b));
        end else begin
            exp = expect_q.pop_front();
            pending = expect_q.size();
            if (exp !== b) begin
                $display("Fail %s: expected 0x%02h, actual 0x%02h", test_name, exp, b);
                test_errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (tx_valid)
                note_error("tx_valid was high during reset");
        end else begin
            if (rx_valid)
                take_rx(rx_data);   // Before tx, DUT is still busy on the last byte
            if (tx_valid)
                take_tx(tx_data);
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (pending != 0)
            note_error($sformatf("%0d reply bytes never arrived", pending));
        $display("Test %s: %s, %0d errors", test_name,
                 test_errors == 0 ? "ok" : "failed", test_errors);
        if (test_errors == 0)
            tests_passed++;
        else
            tests_failed++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d tests ok, %0d tests failed", tests_passed, tests_failed);
    endtask

endmodule

`default_nettype wire

// File: bench/tb_dense_accel.sv
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module tb_dense_accel
    import accel_mem_pkg::*;
();

    localparam int calc_cycles  = 1 + `ACCEL_N_OUT * (2 * `ACCEL_N_IN + 2);
    localparam int link_bytes   = 4 * `ACCEL_MEM_DEPTH + 64;   // Data plus command bytes
    localparam int limit_cycles = 2 * (8 * link_bytes + 2 * calc_cycles + 100);

    logic   clk = 1'b0;
    logic   reset = 1'b1;
    byte_t  rx_data = '0;
    logic   rx_valid = 1'b0;
    byte_t  tx_data;
    logic   tx_valid;
    logic   tx_busy = 1'b0;
    integer seed = 57926;
    byte_t  stim [112];   // Files 0..2, second input vector, junk bytes

    always #5 clk = ~clk;

    dense_accel_top i_dense_accel_top (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_busy  (tx_busy)
    );

    accel_checker i_checker (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_busy  (tx_busy)
    );

    // Host side busy about 30% of cycles
    always @(posedge clk) begin
        #1;
        tx_busy <= ($unsigned($random(seed)) % 10) < 3;
    end

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input byte_t b);
        rx_data  = b;
        rx_valid = 1'b1;
        @(posedge clk);
        #1 rx_valid = 1'b0;
    endtask

    task automatic send_cmd(input byte_t hdr, input file_t f);
        send_byte(hdr);
        send_byte(f[15:8]);
        send_byte(f[7:0]);
    endtask

    task automatic wait_replies();
        while (i_checker.pending != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_file(input file_t f, input int from, input int count);
        int k;
        send_cmd(`ACCEL_HDR_WRITE, f);
        for (k = 0; k < count; k++)
            send_byte(stim[from + k]);
        idle(2);
    endtask

    task automatic read_file(input file_t f);
        send_cmd(`ACCEL_HDR_READ, f);
        wait_replies();
        idle(2);
    endtask

    initial begin
        int k;
        for (k = 0; k < 112; k++)
            stim[k] = $random(seed);
        i_checker.start_test("reset");
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        idle(4);
        i_checker.end_test();

        i_checker.start_test("write_read");
        write_file(0, `ACCEL_IN_BASE, `ACCEL_N_IN);   // stim index equals address here
        write_file(1, `ACCEL_MAT_BASE, `ACCEL_N_IN * `ACCEL_N_OUT);
        write_file(2, `ACCEL_BIAS_BASE, `ACCEL_N_OUT);
        for (k = 0; k < 3; k++)
            read_file(k);
        i_checker.end_test();

        i_checker.start_test("empty_file");
        send_cmd(`ACCEL_HDR_READ, 16'd9);
        send_cmd(`ACCEL_HDR_WRITE, 16'd9);
        read_file(2);
        i_checker.end_test();

        i_checker.start_test("compute");
        send_byte(`ACCEL_HDR_CALC);
        wait_replies();
        read_file(3);
        i_checker.end_test();

        i_checker.start_test("backpressure");
        write_file(0, 88, `ACCEL_N_IN);
        send_byte(`ACCEL_HDR_CALC);
        send_cmd(`ACCEL_HDR_WRITE, 16'd0);   // Lands mid compute, must be dropped
        for (k = 0; k < 8; k++)
            send_byte(stim[104 + k]);
        wait_replies();
        for (k = 0; k < 4; k++)
            read_file(k);
        i_checker.end_test();

        i_checker.print_summary();
        if (i_checker.tests_failed == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial begin
        #(limit_cycles * 10);
        $display("Timeout: the run took longer than %0d cycles", limit_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/accel_config.svh
`ifndef ACCEL_CONFIG_SVH
`define ACCEL_CONFIG_SVH

// Dense layer sizes
`define ACCEL_N_IN       16
`define ACCEL_N_OUT      4

`define ACCEL_MEM_DEPTH  88

// File layout in scratch memory
`define ACCEL_IN_BASE    0
`define ACCEL_MAT_BASE   16   // One row of N_IN weights per output
`define ACCEL_BIAS_BASE  80
`define ACCEL_ANS_BASE   84

// Header bytes on the link
`define ACCEL_HDR_READ   82   // 'R'
`define ACCEL_HDR_WRITE  87   // 'W'
`define ACCEL_HDR_CALC   67   // 'C'
`define ACCEL_ACK_DONE   68   // 'D'

`endif

// File: verilog/accel_ctrl_pkg.sv
`default_nettype none

package accel_ctrl_pkg;

    typedef enum logic [2:0] {
        xfer_idle,
        xfer_idx_hi,
        xfer_idx_lo,
        xfer_read_fetch,
        xfer_read_send,
        xfer_write_data,
        xfer_calc_wait
    } xfer_state_t;

    typedef enum logic [2:0] {
        dense_idle,
        dense_bias,
        dense_fetch_in,
        dense_fetch_w,
        dense_write_ans
    } dense_state_t;

endpackage

`default_nettype wire

// File: verilog/accel_mem_pkg.sv
`default_nettype none

package accel_mem_pkg;

    // One memory or link byte
    typedef logic [7:0] byte_t;

    typedef logic [6:0] addr_t;

    // File index, high byte first on the link
    typedef logic [15:0] file_t;

    // Dense accumulator, only the low byte is kept
    typedef logic [15:0] acc_t;

endpackage

`default_nettype wire

// File: verilog/byte_transfer.sv
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module byte_transfer
    import accel_mem_pkg::*;
    import accel_ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        reset,

    input  wire byte_t rx_data,
    input  wire        rx_valid,
    output byte_t      tx_data,
    output logic       tx_valid,
    input  wire        tx_busy,

    output file_t      file,
    input  wire addr_t first_addr,
    input  wire addr_t last_addr,
    input  wire        file_valid,

    output addr_t      mem_addr,
    output logic       mem_we,
    output byte_t      mem_wdata,
    input  wire byte_t mem_rdata,

    output logic       calc_start,
    input  wire        calc_done
);

    xfer_state_t state;
    byte_t       file_hi;
    addr_t       ptr;
    addr_t       end_addr;
    logic        is_read;
    logic        ack_pending;
    logic        tx_ready;

    // Low index byte is looked up straight off the link
    assign file = {file_hi, rx_data};

    assign mem_addr  = ptr;
    assign mem_we    = (state == xfer_write_data) && rx_valid;
    assign mem_wdata = rx_data;

    assign tx_ready = (state == xfer_read_send) || (state == xfer_calc_wait && ack_pending);
    assign tx_valid = tx_ready && !tx_busy;
    assign tx_data  = (state == xfer_calc_wait) ? byte_t'(`ACCEL_ACK_DONE) : mem_rdata;

    always_ff @(posedge clk) begin
        if (state == xfer_idx_hi && rx_valid)
            file_hi <= rx_data;
        if (state == xfer_idx_lo && rx_valid)
            end_addr <= last_addr;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= xfer_idle;
            ptr         <= '0;
            is_read     <= 1'b0;
            ack_pending <= 1'b0;
            calc_start  <= 1'b0;
        end else begin
            calc_start <= 1'b0;
            case (state)
                xfer_idle: begin
                    if (rx_valid) begin
                        case (rx_data)
                            `ACCEL_HDR_READ: begin
                                is_read <= 1'b1;
                                state   <= xfer_idx_hi;
                            end
                            `ACCEL_HDR_WRITE: begin
                                is_read <= 1'b0;
                                state   <= xfer_idx_hi;
                            end
                            `ACCEL_HDR_CALC: begin
                                calc_start  <= 1'b1;
                                ack_pending <= 1'b0;
                                state       <= xfer_calc_wait;
                            end
                            default: ;   // Unknown header dropped
                        endcase
                    end
                end
                xfer_idx_hi: if (rx_valid) state <= xfer_idx_lo;
                xfer_idx_lo: begin
                    if (rx_valid) begin
                        if (!file_valid) begin
                            state <= xfer_idle;   // Empty file has nothing to move
                        end else begin
                            ptr   <= first_addr;
                            state <= is_read ? xfer_read_fetch : xfer_write_data;
                        end
                    end
                end
                xfer_read_fetch: state <= xfer_read_send;
                xfer_read_send: begin
                    if (!tx_busy) begin
                        if (ptr == end_addr) begin
                            state <= xfer_idle;
                        end else begin
                            ptr   <= ptr + 1'b1;
                            state <= xfer_read_fetch;
                        end
                    end
                end
                xfer_write_data: begin
                    if (rx_valid) begin
                        if (ptr == end_addr)
                            state <= xfer_idle;
                        else
                            ptr <= ptr + 1'b1;
                    end
                end
                xfer_calc_wait: begin
                    if (calc_done)
                        ack_pending <= 1'b1;
                    if (ack_pending && !tx_busy) begin
                        ack_pending <= 1'b0;
                        state       <= xfer_idle;
                    end
                end
                default: state <= xfer_idle;
            endcase
        end
    end

    // A waiting byte stays put until the host side frees up
    assert property (@(posedge clk) disable iff (reset)
        tx_ready && tx_busy |=> tx_ready && $stable(tx_data));

endmodule

`default_nettype wire

// File: verilog/dense_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

module dense_accel_top
    import accel_mem_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire byte_t rx_data,
    input  wire        rx_valid,
    output wire byte_t tx_data,
    output wire        tx_valid,
    input  wire        tx_busy
);

    file_t file;
    addr_t first_addr;
    addr_t last_addr;
    logic  file_valid;

    // Port A belongs to the transfer side, port B to the dense engine
    addr_t a_addr;
    logic  a_we;
    byte_t a_wdata;
    byte_t a_rdata;
    addr_t b_addr;
    logic  b_we;
    byte_t b_wdata;
    byte_t b_rdata;

    logic  calc_start;
    logic  calc_done;

    file_table i_file_table (
        .file       (file),
        .first_addr (first_addr),
        .last_addr  (last_addr),
        .file_valid (file_valid)
    );

    scratch_ram i_scratch_ram (
        .clk     (clk),
        .a_addr  (a_addr),
        .a_we    (a_we),
        .a_wdata (a_wdata),
        .a_rdata (a_rdata),
        .b_addr  (b_addr),
        .b_we    (b_we),
        .b_wdata (b_wdata),
        .b_rdata (b_rdata)
    );

    byte_transfer i_byte_transfer (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_busy    (tx_busy),
        .file       (file),
        .first_addr (first_addr),
        .last_addr  (last_addr),
        .file_valid (file_valid),
        .mem_addr   (a_addr),
        .mem_we     (a_we),
        .mem_wdata  (a_wdata),
        .mem_rdata  (a_rdata),
        .calc_start (calc_start),
        .calc_done  (calc_done)
    );

    dense_engine i_dense_engine (
        .clk       (clk),
        .reset     (reset),
        .start     (calc_start),
        .done      (calc_done),
        .mem_addr  (b_addr),
        .mem_we    (b_we),
        .mem_wdata (b_wdata),
        .mem_rdata (b_rdata)
    );

endmodule

`default_nettype wire

// File: verilog/dense_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module dense_engine
    import accel_mem_pkg::*;
    import accel_ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        start,
    output logic       done,

    output addr_t      mem_addr,
    output logic       mem_we,
    output byte_t      mem_wdata,
    input  wire byte_t mem_rdata
);

    dense_state_t                     state;
    logic [$clog2(`ACCEL_N_IN)-1:0]  in_cnt;
    logic [$clog2(`ACCEL_N_OUT)-1:0] out_cnt;
    acc_t                             acc;
    acc_t                             acc_next;
    byte_t                            in_reg;

    // Read data always belongs to the address of the previous state
    assign acc_next = acc + in_reg * mem_rdata;

    always_comb begin
        case (state)
            dense_bias:     mem_addr = addr_t'(`ACCEL_BIAS_BASE + out_cnt);
            dense_fetch_in: mem_addr = addr_t'(`ACCEL_IN_BASE + in_cnt);
            dense_fetch_w:  mem_addr = addr_t'(`ACCEL_MAT_BASE + out_cnt * `ACCEL_N_IN + in_cnt);
            default:        mem_addr = addr_t'(`ACCEL_ANS_BASE + out_cnt);
        endcase
    end

    assign mem_we    = (state == dense_write_ans);
    assign mem_wdata = acc_next[7:0];   // Last product folded in here

    always_ff @(posedge clk) begin
        if (state == dense_fetch_in)
            acc <= (in_cnt == '0) ? acc_t'(mem_rdata) : acc_next;   // Bias first
        if (state == dense_fetch_w)
            in_reg <= mem_rdata;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= dense_idle;
            in_cnt  <= '0;
            out_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                dense_idle: begin
                    if (start) begin
                        in_cnt  <= '0;
                        out_cnt <= '0;
                        state   <= dense_bias;
                    end
                end
                dense_bias:     state <= dense_fetch_in;
                dense_fetch_in: state <= dense_fetch_w;
                dense_fetch_w: begin
                    if (in_cnt == `ACCEL_N_IN - 1) begin
                        in_cnt <= '0;
                        state  <= dense_write_ans;
                    end else begin
                        in_cnt <= in_cnt + 1'b1;
                        state  <= dense_fetch_in;
                    end
                end
                dense_write_ans: begin
                    if (out_cnt == `ACCEL_N_OUT - 1) begin
                        done  <= 1'b1;
                        state <= dense_idle;
                    end else begin
                        out_cnt <= out_cnt + 1'b1;
                        state   <= dense_bias;
                    end
                end
                default: state <= dense_idle;
            endcase
        end
    end

    // The transfer side must wait for done before the next run
    assert property (@(posedge clk) disable iff (reset) start |-> state == dense_idle);

endmodule

`default_nettype wire

// File: verilog/file_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module file_table
    import accel_mem_pkg::*;
(
    input  wire file_t file,
    output addr_t      first_addr,
    output addr_t      last_addr,
    output logic       file_valid
);

    always_comb begin
        first_addr = '0;
        last_addr  = '0;
        file_valid = 1'b1;
        case (file)
            16'd0: begin   // Input vector
                first_addr = addr_t'(`ACCEL_IN_BASE);
                last_addr  = addr_t'(`ACCEL_MAT_BASE - 1);
            end
            16'd1: begin   // Matrix
                first_addr = addr_t'(`ACCEL_MAT_BASE);
                last_addr  = addr_t'(`ACCEL_BIAS_BASE - 1);
            end
            16'd2: begin   // Bias
                first_addr = addr_t'(`ACCEL_BIAS_BASE);
                last_addr  = addr_t'(`ACCEL_ANS_BASE - 1);
            end
            16'd3: begin   // Answer
                first_addr = addr_t'(`ACCEL_ANS_BASE);
                last_addr  = addr_t'(`ACCEL_MEM_DEPTH - 1);
            end
            default: file_valid = 1'b0;   // Empty file
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/scratch_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "accel_config.svh"

module scratch_ram
    import accel_mem_pkg::*;
(
    input  wire        clk,

    input  wire addr_t a_addr,
    input  wire        a_we,
    input  wire byte_t a_wdata,
    output byte_t      a_rdata,

    input  wire addr_t b_addr,
    input  wire        b_we,
    input  wire byte_t b_wdata,
    output byte_t      b_rdata
);

    byte_t mem [`ACCEL_MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (a_we)
            mem[a_addr] <= a_wdata;
        if (b_we)
            mem[b_addr] <= b_wdata;
        a_rdata <= mem[a_addr];   // Registered read
        b_rdata <= mem[b_addr];
    end

    // Transfer side and dense engine take turns on the memory
    assert property (@(posedge clk) !(a_we && b_we));

endmodule

`default_nettype wire
